// File: Makefile
# Verilator build and run for the heap priority queue testbench.
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= pheapTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) logic/pheap_config.svh

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass message missing from $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: logic/heapLevel.sv
/*
 * One memory level of the heap, LEVEL 2 and deeper. Stores its nodes
 * by position, serves child pairs to the level above, and runs each
 * command in two cycles: latch and read, then compare, write and
 * forward to the next level. The deepest level never forwards.
 */

`timescale 1ns/100ps
`include "pheap_config.svh"

module heapLevel
    import pheapPkg::*;
#(
    parameter int LEVEL = 2
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  levelCmdT                 cmdIn,
    output levelCmdT                 cmdOut,
    input  logic [`PHEAP_LEVELS-1:0] upPairAddr,
    output entryPairT                upPairData,
    output logic [`PHEAP_LEVELS-1:0] pairAddr,
    input  entryPairT                pairData,
    output logic                     levelBusy
);

    localparam int POSW  = `PHEAP_LEVELS;
    localparam int NODES = 1 << (LEVEL - 1);
    localparam int IDXW  = (LEVEL > 1) ? LEVEL - 1 : 1;
    // free slots under one node of this level when the heap is empty
    localparam logic [POSW-1:0] CAP_INIT = POSW'((1 << (POSW - LEVEL + 1)) - 1);

    entryT           nodeMem [NODES];
    levelCmdT        cmdR;
    levelCmdT        fwd;
    entryT           nodeCur;
    entryT           nodeNext;
    entryT           child;
    entryPairT       kids;
    logic            pickRight;
    logic            haveChild;
    logic [IDXW-1:0] nodeIdx;
    logic [IDXW-1:0] leftIdx;
    logic [IDXW-1:0] rightIdx;

    // ------------------------------------------------------------------
    // node storage
    // ------------------------------------------------------------------
    assign leftIdx  = IDXW'({upPairAddr, 1'b0});   // children of parent p sit at 2p, 2p+1
    assign rightIdx = IDXW'({upPairAddr, 1'b1});

    assign upPairData.left  = nodeMem[leftIdx];
    assign upPairData.right = nodeMem[rightIdx];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NODES; i++) begin
                nodeMem[i].active   <= 1'b0;
                nodeMem[i].capacity <= CAP_INIT;
            end
        end else if (cmdR.valid) begin
            nodeMem[nodeIdx] <= nodeNext;
        end
    end

    // ------------------------------------------------------------------
    // read cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        cmdR <= cmdIn;                 // command and its node position
        if (!rstN) begin
            cmdR.valid <= 1'b0;
        end
    end

    assign nodeIdx   = cmdR.pos[IDXW-1:0];
    assign nodeCur   = nodeMem[nodeIdx];
    assign pairAddr  = cmdR.pos;
    assign levelBusy = cmdIn.valid || cmdR.valid;

    assign haveChild = kids.left.active || kids.right.active;
    assign pickRight = kids.right.active &&
                       (!kids.left.active || kids.right.kv.key < kids.left.kv.key);
    assign child     = pickRight ? kids.right : kids.left;

    // ------------------------------------------------------------------
    // compare, write and forward cycle
    // ------------------------------------------------------------------
    always_comb begin
        nodeNext  = nodeCur;
        fwd       = cmdR;
        fwd.valid = 1'b0;
        fwd.pos   = {cmdR.pos[POSW-2:0], pickRight};
        if (cmdR.valid) begin
            case (cmdR.op)
                ENQ: begin
                    nodeNext.active   = 1'b1;
                    nodeNext.capacity = nodeCur.capacity - 1'b1;
                    if (!nodeCur.active) begin
                        nodeNext.kv = cmdR.kv;            // item settles here
                    end else begin
                        fwd.valid = 1'b1;
                        fwd.pos   = {cmdR.pos[POSW-2:0], kids.left.capacity == '0};
                        if (cmdR.kv.key < nodeCur.kv.key) begin
                            nodeNext.kv = cmdR.kv;
                            fwd.kv      = nodeCur.kv;
                        end
                    end
                end
                DEQ: begin
                    // our item moved up, refill from the smaller child
                    nodeNext.capacity = nodeCur.capacity + 1'b1;
                    nodeNext.active   = haveChild;
                    nodeNext.kv       = child.kv;
                    fwd.valid         = haveChild;
                end
                REPLACE: begin
                    if (haveChild && child.kv.key < cmdR.kv.key) begin
                        nodeNext.kv = child.kv;
                        fwd.valid   = 1'b1;
                    end else begin
                        nodeNext.kv = cmdR.kv;
                    end
                end
                default: fwd.valid = 1'b0;
            endcase
        end
    end

    generate
        if (LEVEL == `PHEAP_LEVELS) begin : genBottom
            assign kids   = '0;          // leaves, no children below
            assign cmdOut = '0;
        end else begin : genInner
            assign kids = pairData;
            always_ff @(posedge clk) begin
                cmdOut <= fwd;
                if (!rstN) begin
                    cmdOut.valid <= 1'b0;
                end
            end
        end
    endgenerate

    // the level above only sends an item into a subtree with room
    enqHasRoom: assert property (@(posedge clk) disable iff (!rstN)
        cmdR.valid && cmdR.op == ENQ |-> nodeCur.capacity != '0);

endmodule

// File: logic/heapRoot.sv
/*
 * Level 1 of the heap. Holds the head entry in a register, takes one
 * command at a time from the register block and sends the displaced
 * item or the refill request down to level 2.
 */

`timescale 1ns/100ps
`include "pheap_config.svh"

module heapRoot
    import pheapPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  levelCmdT                 rootCmd,
    output logic [`PHEAP_LEVELS-1:0] pairAddr,
    input  entryPairT                pairData,
    output levelCmdT                 cmdOut,
    output logic                     rootReady,
    output kvT                       head,
    output logic                     empty,
    output logic                     full
);

    localparam int POSW = `PHEAP_LEVELS;

    levelCmdT cmdR;
    levelCmdT fwd;
    entryT    rootE;
    entryT    rootNext;
    entryT    child;
    logic     pickRight;
    logic     haveChild;

    // read cycle, latch the command
    always_ff @(posedge clk) begin
        cmdR <= rootCmd;
        if (!rstN) begin
            cmdR.valid <= 1'b0;
        end
    end

    assign pairAddr  = cmdR.pos;
    assign haveChild = pairData.left.active || pairData.right.active;
    assign pickRight = pairData.right.active &&
                       (!pairData.left.active || pairData.right.kv.key < pairData.left.kv.key);
    assign child     = pickRight ? pairData.right : pairData.left;

    // compare cycle
    always_comb begin
        rootNext  = rootE;
        fwd       = cmdR;             // op and new item travel down unchanged
        fwd.valid = 1'b0;
        fwd.pos   = {cmdR.pos[POSW-2:0], pickRight};
        if (cmdR.valid) begin
            case (cmdR.op)
                ENQ: begin
                    rootNext.active   = 1'b1;
                    rootNext.capacity = rootE.capacity - 1'b1;
                    if (!rootE.active) begin
                        rootNext.kv = cmdR.kv;
                    end else begin
                        fwd.valid = 1'b1;
                        fwd.pos   = {cmdR.pos[POSW-2:0], pairData.left.capacity == '0};
                        if (cmdR.kv.key < rootE.kv.key) begin
                            rootNext.kv = cmdR.kv;
                            fwd.kv      = rootE.kv;   // old head sinks
                        end
                    end
                end
                DEQ: begin
                    rootNext.capacity = rootE.capacity + 1'b1;
                    rootNext.active   = haveChild;
                    rootNext.kv       = child.kv;
                    fwd.valid         = haveChild;
                end
                REPLACE: begin
                    if (haveChild && child.kv.key < cmdR.kv.key) begin
                        rootNext.kv = child.kv;
                        fwd.valid   = 1'b1;
                    end else begin
                        rootNext.kv = cmdR.kv;
                    end
                end
                default: fwd.valid = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cmdOut <= fwd;
        if (!rstN) begin
            cmdOut.valid   <= 1'b0;
            rootE.active   <= 1'b0;
            rootE.capacity <= '1;         // whole heap free
        end else if (cmdR.valid) begin
            rootE <= rootNext;
        end
    end

    assign rootReady = !cmdR.valid;
    assign head      = rootE.kv;
    assign empty     = !rootE.active;
    assign full      = (rootE.capacity == '0);

    // a command is a single-cycle pulse issued only into an idle root
    oneCmdAtATime: assert property (@(posedge clk) disable iff (!rstN)
        rootCmd.valid |-> rootReady ##1 !rootCmd.valid);

endmodule

// File: logic/pheapPkg.sv
/*
 * Shared types of the heap priority queue: the key/value payload, the
 * stored node, the command passed between levels and the STATUS word.
 * Modules pull these in with a wildcard import in their header.
 */

`include "pheap_config.svh"

package pheapPkg;

    typedef struct packed {
        logic [`PHEAP_KEYW-1:0] key;    // ordering field, smallest leaves first
        logic [`PHEAP_VALW-1:0] value;
    } kvT;

    typedef enum logic [1:0] {
        IDLE,
        ENQ,
        DEQ,
        REPLACE
    } heapOpT;

    typedef struct packed {
        kvT                       kv;
        logic                     active;    // node holds an item
        logic [`PHEAP_LEVELS-1:0] capacity;  // free slots in this subtree
    } entryT;

    typedef struct packed {
        entryT left;
        entryT right;
    } entryPairT;

    typedef struct packed {
        logic                     valid;
        heapOpT                   op;
        kvT                       kv;
        logic [`PHEAP_LEVELS-1:0] pos;   // node index within the target level
    } levelCmdT;

    localparam int STAT_CNTW = 27;

    typedef struct packed {
        logic [STAT_CNTW-1:0] count;
        logic                 underflow;
        logic                 overflow;
        logic                 busy;
        logic                 full;
        logic                 empty;     // bit 0
    } pqStatusT;

endpackage

// File: logic/pheapTop.sv
/*
 * Top of the heap priority queue. Connects the Wishbone register block,
 * the root register and the chain of memory levels below it.
 */

`timescale 1ns/100ps
`include "pheap_config.svh"

module pheapTop
    import pheapPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [2:0]  adr,
    input  logic [31:0] datW,
    output logic        ack,
    output logic [31:0] datR
);

    levelCmdT                 rootCmd;
    levelCmdT                 cmdChain  [1:`PHEAP_LEVELS-1];  // command leaving level k
    logic [`PHEAP_LEVELS-1:0] pairAddrs [1:`PHEAP_LEVELS-1];  // child pair asked by level k
    entryPairT                pairDatas [2:`PHEAP_LEVELS];    // pair served by level k
    logic                     levelBusy [2:`PHEAP_LEVELS];
    kvT                       head;
    logic                     empty;
    logic                     full;
    logic                     rootReady;
    logic                     heapReady;

    assign heapReady = rootReady && !levelBusy[2];   // root idle and level 2 drained

    pqRegs uRegs (
        .clk, .rstN, .cyc, .stb, .we, .adr, .datW, .ack, .datR,
        .rootReady(heapReady), .head, .empty, .full, .rootCmd
    );

    heapRoot uRoot (
        .clk, .rstN, .rootCmd, .pairAddr(pairAddrs[1]), .pairData(pairDatas[2]),
        .cmdOut(cmdChain[1]), .rootReady, .head, .empty, .full
    );

    for (genvar lv = 2; lv <= `PHEAP_LEVELS; lv++) begin : genLevel
        if (lv < `PHEAP_LEVELS) begin : genMid
            heapLevel #(.LEVEL(lv)) uLevel (
                .clk, .rstN, .cmdIn(cmdChain[lv-1]), .cmdOut(cmdChain[lv]),
                .upPairAddr(pairAddrs[lv-1]), .upPairData(pairDatas[lv]),
                .pairAddr(pairAddrs[lv]), .pairData(pairDatas[lv+1]),
                .levelBusy(levelBusy[lv])
            );
        end else begin : genLast
            heapLevel #(.LEVEL(lv)) uLevel (
                .clk, .rstN, .cmdIn(cmdChain[lv-1]), .cmdOut(),
                .upPairAddr(pairAddrs[lv-1]), .upPairData(pairDatas[lv]),
                .pairAddr(), .pairData(),
                .levelBusy(levelBusy[lv])
            );
        end
    end

endmodule

// File: logic/pheap_config.svh
/*
 * Build-time parameters of the pipelined heap priority queue.
 * Included by the package and by every module that sizes ports or
 * decodes the Wishbone register map.
 */

`ifndef PHEAP_CONFIG_SVH
`define PHEAP_CONFIG_SVH

// heap geometry, capacity is 2**PHEAP_LEVELS - 1
`define PHEAP_LEVELS 4

// payload widths, key plus value fill one bus word
`define PHEAP_KEYW 16
`define PHEAP_VALW 16

// register map, word index on adr
`define PQ_ADDR_PUSH    3'd0
`define PQ_ADDR_POP     3'd1
`define PQ_ADDR_REPLACE 3'd2
`define PQ_ADDR_HEAD    3'd3
`define PQ_ADDR_STATUS  3'd4

`endif

// File: logic/pqRegs.sv
/*
 * Wishbone classic slave in front of the heap. Turns PUSH, POP and
 * REPLACE writes into one-cycle root commands, answers HEAD and STATUS
 * reads, keeps the entry count and the sticky error flags, and holds
 * ack back while the top of the heap is still busy.
 */

`timescale 1ns/100ps
`include "pheap_config.svh"

module pqRegs
    import pheapPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [2:0]  adr,
    input  logic [31:0] datW,
    output logic        ack,
    output logic [31:0] datR,
    input  logic        rootReady,
    input  kvT          head,
    input  logic        empty,
    input  logic        full,
    output levelCmdT    rootCmd
);

    logic                   req;
    logic                   statusRd;
    logic                   ovfHit;
    logic                   unfHit;
    logic                   overflow;
    logic                   underflow;
    logic [`PHEAP_LEVELS:0] count;
    heapOpT                 nextOp;
    pqStatusT               status;

    // one acceptance per access, only once the heap top has settled
    assign req      = cyc && stb && !ack && !rootCmd.valid && rootReady;
    assign statusRd = req && !we && (adr == `PQ_ADDR_STATUS);
    assign ovfHit   = req && we && (adr == `PQ_ADDR_PUSH) && full;
    assign unfHit   = req && we && (adr == `PQ_ADDR_POP) && empty;

    // ------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------
    always_comb begin
        nextOp = IDLE;
        if (req && we) begin
            case (adr)
                `PQ_ADDR_PUSH:    nextOp = full  ? IDLE : ENQ;
                `PQ_ADDR_POP:     nextOp = empty ? IDLE : DEQ;
                `PQ_ADDR_REPLACE: nextOp = empty ? ENQ  : REPLACE;  // empty heap, plain push
                default:          nextOp = IDLE;
            endcase
        end
    end

    always_comb begin
        status           = '0;
        status.count     = STAT_CNTW'(count);
        status.underflow = underflow;
        status.overflow  = overflow;
        status.busy      = !rootReady;
        status.full      = full;
        status.empty     = empty;
    end

    always_ff @(posedge clk) begin
        rootCmd.op  <= nextOp;
        rootCmd.kv  <= kvT'(datW);
        rootCmd.pos <= '0;                // root is node 0
        if (!rstN) begin
            ack           <= 1'b0;
            rootCmd.valid <= 1'b0;
            count         <= '0;
            overflow      <= 1'b0;
            underflow     <= 1'b0;
        end else begin
            ack           <= req;
            rootCmd.valid <= (nextOp != IDLE);
            if (nextOp == ENQ) begin
                count <= count + 1'b1;
            end else if (nextOp == DEQ) begin
                count <= count - 1'b1;
            end
            overflow  <= (overflow && !statusRd) || ovfHit;
            underflow <= (underflow && !statusRd) || unfHit;
        end
    end

    // read data, sampled together with the ack
    always_ff @(posedge clk) begin
        if (req && !we) begin
            case (adr)
                `PQ_ADDR_HEAD:   datR <= head;
                `PQ_ADDR_STATUS: datR <= status;
                default:         datR <= '0;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    ackInCycle: assert property (@(posedge clk) disable iff (!rstN)
        ack |-> cyc && stb);

    cmdOnlyWhenReady: assert property (@(posedge clk) disable iff (!rstN)
        rootCmd.valid |-> rootReady);

endmodule

// File: verif/pheapTb.sv
/*
 * Testbench for the heap priority queue. Drives the Wishbone slave
 * through pushes, pops and replaces, keeps an unordered queue model of
 * the expected contents and checks every HEAD and STATUS read against it.
 */

`timescale 1ns/100ps
`include "pheap_config.svh"

module pheapTb
    import pheapPkg::*;
();

    localparam int CAP     = (1 << `PHEAP_LEVELS) - 1;
    localparam int TIMEOUT = 200;    // cycles allowed for one ack

    logic        clk;
    logic        rstN;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] datW;
    logic        ack;
    logic [31:0] datR;

    kvT     model[$];                // expected contents, no order kept
    integer seed;
    int     checks;
    int     errors;
    int     busErrors;
    int     timeouts;

    pheapTop i_dut (.clk, .rstN, .cyc, .stb, .we, .adr, .datW, .ack, .datR);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // bus protocol
    // ------------------------------------------------------------------
    ackInBusCycle: assert property (@(posedge clk) disable iff (!rstN)
        ack |-> cyc && stb)
    else begin
        busErrors++;
        $display("ack raised outside a bus cycle at %0t", $time);
    end

    ackSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
        ack |=> !ack)
    else begin
        busErrors++;
        $display("ack held for more than one cycle at %0t", $time);
    end

    // one access, ack sampled on the falling edge where it is stable
    task automatic busAccess(input logic write, input logic [2:0] addr,
                             input logic [31:0] wdata, input string what,
                             output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(posedge clk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= write;
        adr  <= addr;
        datW <= wdata;
        @(negedge clk);
        while (!ack && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            rdata = datR;
        end else begin
            timeouts++;
            $display("bus access '%s' was never acknowledged", what);
        end
        @(posedge clk);
        cyc <= 1'b0;                 // stb drops the cycle after ack
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic expectEq(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    function automatic kvT randItem();
        kvT it;
        it     = kvT'($random(seed));
        it.key = it.key & 16'h003f;  // narrow keys so duplicates show up
        return it;
    endfunction

    function automatic int minIndex();
        int best;
        best = 0;
        for (int i = 1; i < model.size(); i++) begin
            if (model[i].key < model[best].key) begin
                best = i;
            end
        end
        return best;
    endfunction

    // ------------------------------------------------------------------
    // register level helpers
    // ------------------------------------------------------------------
    task automatic checkStatus(input string name, input logic expOvf, input logic expUnf);
        logic [31:0] rd;
        pqStatusT    st;
        busAccess(1'b0, `PQ_ADDR_STATUS, '0, {name, " status read"}, rd);
        st = pqStatusT'(rd);
        expectEq({name, " count"}, model.size(), st.count);
        expectEq({name, " empty"}, model.size() == 0, st.empty);
        expectEq({name, " full"}, model.size() == CAP, st.full);
        expectEq({name, " busy"}, 1'b0, st.busy);
        expectEq({name, " overflow"}, expOvf, st.overflow);
        expectEq({name, " underflow"}, expUnf, st.underflow);
    endtask

    task automatic pushItem(input string name, input kvT item);
        logic [31:0] rd;
        busAccess(1'b1, `PQ_ADDR_PUSH, item, {name, " push"}, rd);
        if (model.size() < CAP) begin
            model.push_back(item);   // a push into a full heap is dropped
        end
    endtask

    // reads HEAD, checks it against the model minimum and retires that entry
    task automatic takeHead(input string name, output kvT got);
        logic [31:0] rd;
        int          hit;
        int          best;
        busAccess(1'b0, `PQ_ADDR_HEAD, '0, {name, " head read"}, rd);
        got  = kvT'(rd);
        best = minIndex();
        hit  = -1;
        expectEq({name, " head key"}, model[best].key, got.key);
        foreach (model[i]) begin
            if (hit < 0 && model[i] == got) begin
                hit = i;
            end
        end
        // equal keys leave in any order, so look for the exact entry
        if (hit < 0) begin
            expectEq({name, " head entry"}, model[best], got);
            hit = best;
        end
        model.delete(hit);
    endtask

    task automatic drainAll(input string name);
        kvT          got;
        logic [15:0] lastKey;
        logic [31:0] rd;
        lastKey = '0;
        while (model.size() > 0) begin
            takeHead(name, got);
            checks++;
            assert (got.key >= lastKey)
            else begin
                errors++;
                $display("ERROR %s order: expected key >= %0h, actual %0h",
                         name, lastKey, got.key);
            end
            lastKey = got.key;
            busAccess(1'b1, `PQ_ADDR_POP, '0, {name, " pop"}, rd);
            checkStatus(name, 1'b0, 1'b0);
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        kvT          item;
        logic [31:0] rd;
        seed      = 68;
        checks    = 0;
        errors    = 0;
        busErrors = 0;
        timeouts  = 0;
        rstN      = 1'b0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        datW      = '0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        checkStatus("reset", 1'b0, 1'b0);

        for (int i = 0; i < 12; i++) begin
            pushItem("ordered", randItem());
            checkStatus("ordered", 1'b0, 1'b0);
        end
        drainAll("ordered");

        // replace swaps the head for a new item, count unchanged
        for (int i = 0; i < 6; i++) begin
            pushItem("replace", randItem());
        end
        checkStatus("replace", 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            takeHead("replace", item);
            item = randItem();
            busAccess(1'b1, `PQ_ADDR_REPLACE, item, "replace write", rd);
            model.push_back(item);
            checkStatus("replace", 1'b0, 1'b0);
        end
        drainAll("replace");

        // back-to-back fill runs into back-pressure
        for (int i = 0; i < CAP; i++) begin
            pushItem("fill", randItem());
        end
        checkStatus("fill", 1'b0, 1'b0);
        pushItem("overflow", randItem());
        checkStatus("overflow", 1'b1, 1'b0);
        checkStatus("overflow clear", 1'b0, 1'b0);
        drainAll("fill");

        busAccess(1'b1, `PQ_ADDR_POP, '0, "underflow pop", rd);
        checkStatus("underflow", 1'b0, 1'b1);
        checkStatus("underflow clear", 1'b0, 1'b0);
        item = randItem();
        busAccess(1'b1, `PQ_ADDR_REPLACE, item, "replace on empty", rd);
        model.push_back(item);
        checkStatus("replace on empty", 1'b0, 1'b0);
        busAccess(1'b0, `PQ_ADDR_HEAD, '0, "replace on empty head read", rd);
        expectEq("replace on empty head", item, rd);
        drainAll("replace on empty");

        $display("checks %0d, value errors %0d, bus errors %0d, timeouts %0d",
                 checks, errors, busErrors, timeouts);
        if (errors + busErrors + timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/pheapPkg.sv
logic/pqRegs.sv
logic/heapRoot.sv
logic/heapLevel.sv
logic/pheapTop.sv
verif/pheapTb.sv
